// ==== memCtrl_defs.svh ====
`ifndef MEM_CTRL_DEFS_SVH
`define MEM_CTRL_DEFS_SVH

// RAM geometry for the shared byte memory

// byte address bits actually decoded
// upper address bits are ignored, so accesses wrap
`define MEM_ADDR_W 12

// number of bytes in the RAM
`define MEM_DEPTH (1 << `MEM_ADDR_W)

// a full word is four byte beats
// the beat index and byte counters are sized for that
// and lenCode_t carries the last index directly

// fetch and data ports share this one memory
// so both see the same wrap

`endif

// ==== memCtrlPkg.sv ====
`default_nettype none

`include "memCtrl_defs.svh"

package memCtrlPkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [7:0] byte_t;

    // encoding is the index of the last byte
    typedef enum logic [1:0] {
        LEN_BYTE = 2'd0,
        LEN_HALF = 2'd1,
        LEN_WORD = 2'd3
    } lenCode_t;

    typedef enum logic [1:0] {
        ACC_FETCH = 2'd0,
        ACC_LOAD = 2'd1,
        ACC_STORE = 2'd2
    } accKind_t;

    typedef struct packed {
        accKind_t kind;
        lenCode_t len;
        addr_t addr;
        word_t wdata;
    } memReq_t;

    typedef struct packed {
        logic write;
        logic [`MEM_ADDR_W-1:0] addr;
        byte_t wdata;
    } ramOp_t;

    typedef struct packed {
        logic valid;
        accKind_t kind;
        logic [1:0] index;
        logic last;
    } beatTag_t;

    typedef enum logic {
        SEQ_IDLE = 1'b0,
        SEQ_RUN = 1'b1
    } seqState_t;

endpackage

`default_nettype wire

// ==== reqArbiter.sv ====
`default_nettype none

module reqArbiter (
    input wire clk,
    input wire rst,
    input wire i_hold,
    input wire i_fetchEn,
    input wire memCtrlPkg::addr_t i_fetchAddr,
    input wire i_dataEn,
    input wire i_dataIsStore,
    input wire memCtrlPkg::lenCode_t i_dataLen,
    input wire memCtrlPkg::addr_t i_dataAddr,
    input wire memCtrlPkg::word_t i_dataWr,
    input wire i_xferDone,
    output logic o_reqValid,
    output memCtrlPkg::memReq_t o_req
);

    logic busy;
    logic idle;
    logic accept;
    memCtrlPkg::memReq_t nextReq;

    // the done cycle already counts as idle
    assign idle = !busy || i_xferDone;
    assign accept = idle && (i_dataEn || i_fetchEn);

    // data port wins a tie
    always_comb begin
        nextReq.kind = memCtrlPkg::ACC_FETCH;
        nextReq.len = memCtrlPkg::LEN_WORD;
        nextReq.addr = i_fetchAddr;
        nextReq.wdata = '0;
        if (i_dataEn) begin
            if (i_dataIsStore) begin
                nextReq.kind = memCtrlPkg::ACC_STORE;
            end else begin
                nextReq.kind = memCtrlPkg::ACC_LOAD;
            end
            nextReq.len = i_dataLen;
            nextReq.addr = i_dataAddr;
            nextReq.wdata = i_dataWr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            o_reqValid <= 1'b0;
        end else if (!i_hold) begin
            o_reqValid <= accept;
            if (accept) begin
                busy <= 1'b1;
            end else if (i_xferDone) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!i_hold && accept) begin
            o_req <= nextReq;
        end
    end

endmodule

`default_nettype wire

// ==== byteSequencer.sv ====
`default_nettype none

`include "memCtrl_defs.svh"

module byteSequencer (
    input wire clk,
    input wire rst,
    input wire i_hold,
    input wire i_reqValid,
    input wire memCtrlPkg::memReq_t i_req,
    output memCtrlPkg::ramOp_t o_ramOp,
    output memCtrlPkg::beatTag_t o_beat
);

    memCtrlPkg::seqState_t state;
    memCtrlPkg::memReq_t reqQ;
    logic [1:0] cnt;

    memCtrlPkg::memReq_t src;
    logic [1:0] idx;
    logic issue;
    logic lastBeat;
    memCtrlPkg::addr_t byteAddr;

    // byte 0 goes out straight from the strobe, later bytes from the latch
    always_comb begin
        if (state == memCtrlPkg::SEQ_IDLE) begin
            src = i_req;
            idx = 2'd0;
            issue = i_reqValid;
        end else begin
            src = reqQ;
            idx = cnt;
            issue = 1'b1;
        end
        lastBeat = (idx == src.len);
        byteAddr = src.addr + memCtrlPkg::addr_t'(idx);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= memCtrlPkg::SEQ_IDLE;
            cnt <= 2'd0;
            o_ramOp.write <= 1'b0;
            o_beat.valid <= 1'b0;
        end else if (!i_hold) begin
            o_ramOp.write <= issue && (src.kind == memCtrlPkg::ACC_STORE);
            o_beat.valid <= issue;
            if (issue) begin
                if (lastBeat) begin
                    state <= memCtrlPkg::SEQ_IDLE;
                    cnt <= 2'd0;
                end else begin
                    state <= memCtrlPkg::SEQ_RUN;
                    cnt <= idx + 2'd1;
                end
            end
        end
    end

    // payload side, qualified by write and valid
    always_ff @(posedge clk) begin
        if (!i_hold) begin
            o_ramOp.addr <= byteAddr[`MEM_ADDR_W-1:0];
            o_ramOp.wdata <= src.wdata[{idx, 3'b000} +: 8];
            o_beat.kind <= src.kind;
            o_beat.index <= idx;
            o_beat.last <= lastBeat;
            if (state == memCtrlPkg::SEQ_IDLE && i_reqValid) begin
                reqQ <= i_req;
            end
        end
    end

endmodule

`default_nettype wire

// ==== respAssembler.sv ====
`default_nettype none

module respAssembler (
    input wire clk,
    input wire rst,
    input wire i_hold,
    input wire memCtrlPkg::beatTag_t i_beat,
    input wire memCtrlPkg::byte_t i_rdByte,
    output logic o_fetchDone,
    output memCtrlPkg::word_t o_fetchInst,
    output logic o_dataDone,
    output memCtrlPkg::word_t o_dataRd,
    output logic o_xferDone
);

    memCtrlPkg::word_t collect;
    memCtrlPkg::word_t merged;
    logic finish;

    assign finish = i_beat.valid && i_beat.last;

    // lanes above the last index are left over from older accesses
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            if (k < int'(i_beat.index)) begin
                merged[k*8 +: 8] = collect[k*8 +: 8];
            end else if (k == int'(i_beat.index)) begin
                merged[k*8 +: 8] = i_rdByte;
            end else begin
                merged[k*8 +: 8] = 8'h00;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_fetchDone <= 1'b0;
            o_dataDone <= 1'b0;
            o_xferDone <= 1'b0;
        end else if (!i_hold) begin
            o_fetchDone <= finish && (i_beat.kind == memCtrlPkg::ACC_FETCH);
            o_dataDone <= finish && (i_beat.kind != memCtrlPkg::ACC_FETCH);
            o_xferDone <= finish;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_hold) begin
            if (i_beat.valid) begin
                collect[{i_beat.index, 3'b000} +: 8] <= i_rdByte;
            end
            if (finish) begin
                case (i_beat.kind)
                    memCtrlPkg::ACC_FETCH: o_fetchInst <= merged;
                    memCtrlPkg::ACC_LOAD: o_dataRd <= merged;
                    // store bytes read back are not returned
                    default: o_dataRd <= '0;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== byteRam.sv ====
`default_nettype none

`include "memCtrl_defs.svh"

module byteRam (
    input wire clk,
    input wire i_hold,
    input wire memCtrlPkg::ramOp_t i_op,
    output memCtrlPkg::byte_t o_rdByte
);

    memCtrlPkg::byte_t mem [`MEM_DEPTH];

    // read returns the old byte on a write to the same address
    always_ff @(posedge clk) begin
        if (!i_hold) begin
            if (i_op.write) begin
                mem[i_op.addr] <= i_op.wdata;
            end
            o_rdByte <= mem[i_op.addr];
        end
    end

endmodule

`default_nettype wire

// ==== memSubsys.sv ====
`default_nettype none

module memSubsys (
    input wire clk,
    input wire rst,
    input wire i_ioBufferFull,
    input wire i_fetchEn,
    input wire memCtrlPkg::addr_t i_fetchAddr,
    input wire i_dataEn,
    input wire i_dataIsStore,
    input wire memCtrlPkg::lenCode_t i_dataLen,
    input wire memCtrlPkg::addr_t i_dataAddr,
    input wire memCtrlPkg::word_t i_dataWr,
    output logic o_fetchDone,
    output memCtrlPkg::word_t o_fetchInst,
    output logic o_dataDone,
    output memCtrlPkg::word_t o_dataRd
);

    logic reqValid;
    logic xferDone;
    memCtrlPkg::memReq_t req;
    memCtrlPkg::ramOp_t ramOp;
    memCtrlPkg::beatTag_t beat;
    memCtrlPkg::beatTag_t beatQ;
    memCtrlPkg::byte_t rdByte;

    reqArbiter reqArbiter_i (
        .clk(clk),
        .rst(rst),
        .i_hold(i_ioBufferFull),
        .i_fetchEn(i_fetchEn),
        .i_fetchAddr(i_fetchAddr),
        .i_dataEn(i_dataEn),
        .i_dataIsStore(i_dataIsStore),
        .i_dataLen(i_dataLen),
        .i_dataAddr(i_dataAddr),
        .i_dataWr(i_dataWr),
        .i_xferDone(xferDone),
        .o_reqValid(reqValid),
        .o_req(req)
    );

    byteSequencer byteSequencer_i (
        .clk(clk),
        .rst(rst),
        .i_hold(i_ioBufferFull),
        .i_reqValid(reqValid),
        .i_req(req),
        .o_ramOp(ramOp),
        .o_beat(beat)
    );

    byteRam byteRam_i (
        .clk(clk),
        .i_hold(i_ioBufferFull),
        .i_op(ramOp),
        .o_rdByte(rdByte)
    );

    // matches the one cycle of RAM read latency
    always_ff @(posedge clk) begin
        if (rst) begin
            beatQ.valid <= 1'b0;
        end else if (!i_ioBufferFull) begin
            beatQ <= beat;
        end
    end

    respAssembler respAssembler_i (
        .clk(clk),
        .rst(rst),
        .i_hold(i_ioBufferFull),
        .i_beat(beatQ),
        .i_rdByte(rdByte),
        .o_fetchDone(o_fetchDone),
        .o_fetchInst(o_fetchInst),
        .o_dataDone(o_dataDone),
        .o_dataRd(o_dataRd),
        .o_xferDone(xferDone)
    );

endmodule

`default_nettype wire

// ==== tbMemSubsys.sv ====
`default_nettype none

`include "memCtrl_defs.svh"

module tbMemSubsys;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int DONE_TIMEOUT = 40;

    typedef enum logic [1:0] {
        PORT_FETCH,
        PORT_DATA,
        PORT_BOTH
    } portSel_t;

    typedef struct packed {
        portSel_t port;
        memCtrlPkg::accKind_t kind;
        memCtrlPkg::lenCode_t len;
        logic [31:0] addr;
        logic [31:0] wdata;
        int holdStart;
        int holdLen;
        logic [31:0] expData;
        logic [31:0] expFetch;
    } opRow_t;

    logic clk;
    logic rst;
    logic ioBufferFull;
    logic fetchEn;
    logic [31:0] fetchAddr;
    logic dataEn;
    logic dataIsStore;
    memCtrlPkg::lenCode_t dataLen;
    logic [31:0] dataAddr;
    logic [31:0] dataWr;
    logic fetchDone;
    logic [31:0] fetchInst;
    logic dataDone;
    logic [31:0] dataRd;

    integer seed;
    logic [7:0] shadow [`MEM_DEPTH];
    opRow_t opTable[$];

    memSubsys memSubsys_i (
        .clk(clk),
        .rst(rst),
        .i_ioBufferFull(ioBufferFull),
        .i_fetchEn(fetchEn),
        .i_fetchAddr(fetchAddr),
        .i_dataEn(dataEn),
        .i_dataIsStore(dataIsStore),
        .i_dataLen(dataLen),
        .i_dataAddr(dataAddr),
        .i_dataWr(dataWr),
        .o_fetchDone(fetchDone),
        .o_fetchInst(fetchInst),
        .o_dataDone(dataDone),
        .o_dataRd(dataRd)
    );

    always #4 clk = ~clk;

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
            input logic [31:0] actual);
        if (actual !== expected) begin
            abortRun($sformatf("** Error at %0d ns: %s expected %h, got %h",
                $time, name, expected, actual));
        end
    endtask

    function automatic int lenBytes(input memCtrlPkg::lenCode_t len);
        case (len)
            memCtrlPkg::LEN_BYTE: return 1;
            memCtrlPkg::LEN_HALF: return 2;
            default: return 4;
        endcase
    endfunction

    // little endian, zero extended, wraps like the RAM address
    function automatic logic [31:0] shadowRead(input logic [31:0] addr, input int nBytes);
        logic [31:0] value;
        logic [31:0] byteAddr;
        value = '0;
        for (int i = 0; i < nBytes; i++) begin
            byteAddr = addr + 32'(i);
            value[i*8 +: 8] = shadow[byteAddr[`MEM_ADDR_W-1:0]];
        end
        return value;
    endfunction

    task automatic addRow(input portSel_t port, input memCtrlPkg::accKind_t kind,
            input memCtrlPkg::lenCode_t len, input logic [31:0] addr,
            input int holdStart, input int holdLen);
        opRow_t row;
        logic [31:0] byteAddr;
        row.port = port;
        row.kind = kind;
        row.len = len;
        row.addr = addr;
        row.wdata = $random(seed);
        row.holdStart = holdStart;
        row.holdLen = holdLen;
        row.expData = '0;
        row.expFetch = '0;
        if (kind == memCtrlPkg::ACC_STORE) begin
            for (int i = 0; i < lenBytes(len); i++) begin
                byteAddr = addr + 32'(i);
                shadow[byteAddr[`MEM_ADDR_W-1:0]] = row.wdata[i*8 +: 8];
            end
        end else if (kind == memCtrlPkg::ACC_LOAD) begin
            row.expData = shadowRead(addr, lenBytes(len));
        end
        // a fetch sees the data access that beat it
        if (port != PORT_DATA) begin
            row.expFetch = shadowRead(addr, 4);
        end
        opTable.push_back(row);
    endtask

    task automatic buildTable();
        logic [31:0] addrA;
        logic [31:0] addrB;
        logic [31:0] addrC;
        logic [31:0] addrD;
        addrA = $random(seed) & 32'h0000_0fff;
        addrB = $random(seed) & 32'h0000_0fff;
        addrC = $random(seed) & 32'h0000_0fff;
        addrD = $random(seed) & 32'h0000_0fff;
        addRow(PORT_DATA, memCtrlPkg::ACC_STORE, memCtrlPkg::LEN_WORD, addrA, 0, 0);
        addRow(PORT_FETCH, memCtrlPkg::ACC_FETCH, memCtrlPkg::LEN_WORD, addrA, 0, 0);
        addRow(PORT_DATA, memCtrlPkg::ACC_STORE, memCtrlPkg::LEN_BYTE, addrB, 0, 0);
        addRow(PORT_DATA, memCtrlPkg::ACC_STORE, memCtrlPkg::LEN_HALF, addrB + 1, 0, 0);
        addRow(PORT_DATA, memCtrlPkg::ACC_STORE, memCtrlPkg::LEN_BYTE, addrB + 3, 0, 0);
        addRow(PORT_DATA, memCtrlPkg::ACC_LOAD, memCtrlPkg::LEN_WORD, addrB, 0, 0);
        addRow(PORT_DATA, memCtrlPkg::ACC_LOAD, memCtrlPkg::LEN_BYTE, addrB + 1, 0, 0);
        addRow(PORT_DATA, memCtrlPkg::ACC_LOAD, memCtrlPkg::LEN_HALF, addrB + 2, 0, 0);
        // hold in the middle of the byte beats
        addRow(PORT_DATA, memCtrlPkg::ACC_STORE, memCtrlPkg::LEN_WORD, addrC, 2, 3);
        addRow(PORT_DATA, memCtrlPkg::ACC_LOAD, memCtrlPkg::LEN_WORD, addrC, 3, 4);
        addRow(PORT_DATA, memCtrlPkg::ACC_LOAD, memCtrlPkg::LEN_HALF, addrC + 1, 1, 2);
        addRow(PORT_BOTH, memCtrlPkg::ACC_STORE, memCtrlPkg::LEN_WORD, addrD, 0, 0);
        addRow(PORT_BOTH, memCtrlPkg::ACC_LOAD, memCtrlPkg::LEN_HALF, addrB, 0, 0);
        // top of the RAM wraps to address zero
        addRow(PORT_DATA, memCtrlPkg::ACC_STORE, memCtrlPkg::LEN_WORD, 32'h0000_1ffe, 0, 0);
        addRow(PORT_DATA, memCtrlPkg::ACC_LOAD, memCtrlPkg::LEN_WORD, 32'h0000_0ffe, 0, 0);
        addRow(PORT_FETCH, memCtrlPkg::ACC_FETCH, memCtrlPkg::LEN_WORD, 32'hffff_fffe, 0, 0);
    endtask

    // first edge is acceptance, edges counts from there to the done edge
    task automatic awaitDone(input logic wantData, input int holdStart, input int holdLen,
            output int edges);
        logic seen;
        seen = 1'b0;
        edges = 0;
        @(posedge clk);
        while (!seen) begin
            @(negedge clk);
            if (dataDone && fetchDone) begin
                abortRun("both done outputs pulsed in the same cycle");
            end else if (dataDone || fetchDone) begin
                if (wantData && fetchDone) begin
                    abortRun("fetch done pulsed while a data access was pending");
                end else if (!wantData && dataDone) begin
                    abortRun("data done pulsed while a fetch was pending");
                end
                seen = 1'b1;
            end else if (edges >= DONE_TIMEOUT) begin
                abortRun("timed out waiting for a done pulse");
            end else begin
                ioBufferFull = (holdLen > 0) && (edges >= holdStart)
                    && (edges < holdStart + holdLen);
                @(posedge clk);
                edges++;
            end
        end
        ioBufferFull = 1'b0;
    endtask

    task automatic runRow(input opRow_t row);
        int edges;
        if (row.port != PORT_FETCH) begin
            dataEn = 1'b1;
            dataIsStore = (row.kind == memCtrlPkg::ACC_STORE);
            dataLen = row.len;
            dataAddr = row.addr;
            dataWr = row.wdata;
        end
        if (row.port != PORT_DATA) begin
            fetchEn = 1'b1;
            fetchAddr = row.addr;
        end
        if (row.port == PORT_FETCH) begin
            awaitDone(1'b0, row.holdStart, row.holdLen, edges);
            checkValue("o_fetchInst", row.expFetch, fetchInst);
            checkValue("fetch latency", 6 + row.holdLen, edges);
        end else begin
            awaitDone(1'b1, row.holdStart, row.holdLen, edges);
            checkValue("o_dataRd", row.expData, dataRd);
            checkValue("data latency", lenBytes(row.len) + 2 + row.holdLen, edges);
        end
        // fetch stays up and goes next
        dataEn = 1'b0;
        if (row.port == PORT_BOTH) begin
            awaitDone(1'b0, 0, 0, edges);
            checkValue("o_fetchInst", row.expFetch, fetchInst);
            checkValue("fetch latency", 6, edges);
        end
        fetchEn = 1'b0;
        @(negedge clk);
        checkValue("o_fetchDone", 32'd0, 32'(fetchDone));
        checkValue("o_dataDone", 32'd0, 32'(dataDone));
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        ioBufferFull = 1'b0;
        fetchEn = 1'b0;
        fetchAddr = '0;
        dataEn = 1'b0;
        dataIsStore = 1'b0;
        dataLen = memCtrlPkg::LEN_BYTE;
        dataAddr = '0;
        dataWr = '0;
        seed = 32'hca1c1347;
        buildTable();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        checkValue("o_fetchDone", 32'd0, 32'(fetchDone));
        checkValue("o_dataDone", 32'd0, 32'(dataDone));
        foreach (opTable[n]) begin
            runRow(opTable[n]);
        end
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+.
memCtrlPkg.sv
reqArbiter.sv
byteSequencer.sv
respAssembler.sv
byteRam.sv
memSubsys.sv
tbMemSubsys.sv

// ==== runSim.sh ====
#!/bin/sh
# build with Verilator and run, the exit status carries pass or fail
cd "$(dirname "$0")" \
    && verilator --binary --timing --top-module tbMemSubsys -f sources.f \
    && ./obj_dir/VtbMemSubsys \
    || exit 1
